// ==== eth_mac_settings.svh ====
// ==============================
// Ethernet MAC transmit settings
// Frame layout and CRC constants
// ==============================

`ifndef ETH_MAC_SETTINGS_SVH
`define ETH_MAC_SETTINGS_SVH

// Framing
`define ETH_PREAMBLE_LEN 7                    // Bytes of 0x55
`define ETH_SFD          8'hD5
`define ETH_HDR_LEN      14                   // Destination, source, type
`define ETH_LOCAL_MAC    48'h02_00_00_00_00_01
`define ETH_TYPE_IPV4    16'h0800
`define ETH_IFG_LEN      12                   // Idle cycles after a frame

// Payload limits
`define ETH_MAX_PAYLOAD  1500
`define ETH_LEN_W        16

// CRC-32 start value
`define ETH_CRC_INIT     32'hFFFF_FFFF

`endif

// ==== eth_mac_pkg.sv ====
// ==============================
// Ethernet MAC transmit types
// Phase encoding, payload word view and CRC-32 byte step
// ==============================

package eth_mac_pkg;

    // Sequencer phases, in frame order
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PREAMBLE,
        PH_SFD,
        PH_HEADER,
        PH_PAYLOAD,
        PH_CRC,
        PH_GAP
    } tx_phase_e;

    // One host word, seen whole or as bytes
    // bytes[0] is the first byte on the wire
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
    } payload_word_u;

    // Reflected IEEE 802.3 polynomial
    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;

    // ==============================
    // CRC-32 over one byte, LSB first
    // ==============================
    function automatic logic [31:0] crc32_update(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== payload_byte_if.sv ====
// ==============================
// Payload byte link
// Unpacker hands bytes to the frame sequencer
// ==============================

interface payload_byte_if;

    logic       need;   // Frame wants payload words
    logic       flush;  // End of payload, drop leftovers
    logic [7:0] data;   // Current byte
    logic       avail;  // data is valid
    logic       take;   // Byte consumed this cycle

    modport sequencer (
        output need,
        output flush,
        output take,
        input  data,
        input  avail
    );

    modport unpacker (
        input  need,
        input  flush,
        input  take,
        output data,
        output avail
    );

endinterface

// ==== payload_unpacker.sv ====
// ==============================
// Payload unpacker
// Takes 32-bit host words and presents them byte by byte
// ==============================

`include "eth_mac_settings.svh"

module payload_unpacker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       word_valid,
    input  eth_mac_pkg::payload_word_u word_data,
    output logic                       word_ready,
    payload_byte_if.unpacker           pb
);

    eth_mac_pkg::payload_word_u word_q;  // Buffered host word
    logic [1:0]                 idx;     // Next byte within word_q
    logic                       full;
    logic                       last_byte;
    logic                       load;

    // Final byte of the buffer goes out this cycle
    assign last_byte = pb.take && (idx == 2'd3);

    // Refill when empty or while the last byte drains
    assign word_ready = pb.need && (!full || last_byte);
    assign load       = word_valid && word_ready;

    assign pb.avail = full;
    assign pb.data  = word_q.bytes[idx];  // Same-cycle byte for take

    // ==============================
    // Buffer control
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            idx  <= 2'd0;
        end else if (pb.flush) begin
            full <= 1'b0;  // Unused tail of the last word
            idx  <= 2'd0;
        end else if (load) begin
            full <= 1'b1;
            idx  <= 2'd0;
        end else if (pb.take) begin
            idx <= idx + 2'd1;
            if (idx == 2'd3) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q.word <= word_data.word;
        end
    end

    // Sequencer only consumes bytes that are present
    take_needs_avail: assert property (
        @(posedge clk) disable iff (!rst_n)
        pb.take |-> pb.avail
    ) else $error("payload byte taken while none available");

endmodule

// ==== tx_frame_sequencer.sv ====
// ==============================
// Transmit frame sequencer
// Orders preamble, SFD, header, payload, CRC slot and gap
// Counts completed frames
// ==============================

`include "eth_mac_settings.svh"

module tx_frame_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pkt_valid,
    input  logic [`ETH_LEN_W-1:0] pkt_len,
    output logic                  pkt_ready,
    payload_byte_if.sequencer     pb,
    output logic [7:0]            byte_data,
    output logic                  byte_en,
    output logic                  byte_er,
    output logic                  crc_en,
    output logic                  crc_slot,
    output logic [31:0]           packet_counter
);

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam int         HDR_BITS      = `ETH_HDR_LEN * 8;

    // Broadcast destination, local source, EtherType
    localparam logic [HDR_BITS-1:0] HDR = {48'hFFFF_FFFF_FFFF, `ETH_LOCAL_MAC, `ETH_TYPE_IPV4};

    eth_mac_pkg::tx_phase_e phase;
    eth_mac_pkg::tx_phase_e phase_nxt;
    logic [`ETH_LEN_W-1:0]  cnt;        // Byte or cycle within phase
    logic [`ETH_LEN_W-1:0]  len_q;      // Payload length of this frame
    logic [`ETH_LEN_W-1:0]  phase_len;
    logic                   last;
    logic [3:0]             hdr_idx;

    logic [7:0] data_d;
    logic       en_d;
    logic       er_d;
    logic       crc_en_d;
    logic       slot_d;

    // ==============================
    // Phase lengths and order
    // ==============================
    always_comb begin
        phase_len = `ETH_LEN_W'(1);
        phase_nxt = eth_mac_pkg::PH_IDLE;
        case (phase)
            eth_mac_pkg::PH_PREAMBLE: begin
                phase_len = `ETH_LEN_W'(`ETH_PREAMBLE_LEN);
                phase_nxt = eth_mac_pkg::PH_SFD;
            end
            eth_mac_pkg::PH_SFD: begin
                phase_len = `ETH_LEN_W'(1);
                phase_nxt = eth_mac_pkg::PH_HEADER;
            end
            eth_mac_pkg::PH_HEADER: begin
                phase_len = `ETH_LEN_W'(`ETH_HDR_LEN);
                phase_nxt = eth_mac_pkg::PH_PAYLOAD;
            end
            eth_mac_pkg::PH_PAYLOAD: begin
                phase_len = len_q;
                phase_nxt = eth_mac_pkg::PH_CRC;
            end
            eth_mac_pkg::PH_CRC: begin
                phase_len = `ETH_LEN_W'(4);
                phase_nxt = eth_mac_pkg::PH_GAP;
            end
            eth_mac_pkg::PH_GAP: begin
                phase_len = `ETH_LEN_W'(`ETH_IFG_LEN);
                phase_nxt = eth_mac_pkg::PH_IDLE;
            end
            default: ;
        endcase
    end

    assign last    = (cnt == phase_len - `ETH_LEN_W'(1));
    assign hdr_idx = 4'(`ETH_HDR_LEN - 1) - cnt[3:0];  // Header goes out MSB first

    // Payload pull
    assign pkt_ready = (phase == eth_mac_pkg::PH_IDLE);
    assign pb.take   = (phase == eth_mac_pkg::PH_PAYLOAD) && pb.avail;
    assign pb.flush  = (phase == eth_mac_pkg::PH_PAYLOAD) && last;
    assign pb.need   = (phase == eth_mac_pkg::PH_PREAMBLE) ||
                       (phase == eth_mac_pkg::PH_SFD) ||
                       (phase == eth_mac_pkg::PH_HEADER) ||
                       ((phase == eth_mac_pkg::PH_PAYLOAD) && !last);

    // ==============================
    // Byte for the current cycle
    // ==============================
    always_comb begin
        data_d   = 8'h00;
        en_d     = 1'b0;
        er_d     = 1'b0;
        crc_en_d = 1'b0;
        slot_d   = 1'b0;
        case (phase)
            eth_mac_pkg::PH_PREAMBLE: begin
                data_d = PREAMBLE_BYTE;
                en_d   = 1'b1;
            end
            eth_mac_pkg::PH_SFD: begin
                data_d = `ETH_SFD;
                en_d   = 1'b1;
            end
            eth_mac_pkg::PH_HEADER: begin
                data_d   = HDR[hdr_idx*8 +: 8];
                en_d     = 1'b1;
                crc_en_d = 1'b1;
            end
            eth_mac_pkg::PH_PAYLOAD: begin
                data_d   = pb.data;
                en_d     = 1'b1;
                er_d     = !pb.avail;  // Underrun keeps its byte slot
                crc_en_d = 1'b1;
            end
            eth_mac_pkg::PH_CRC: begin
                en_d   = 1'b1;
                slot_d = 1'b1;  // Filled in by the CRC stage
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase          <= eth_mac_pkg::PH_IDLE;
            cnt            <= '0;
            len_q          <= '0;
            packet_counter <= 32'd0;
            byte_data      <= 8'h00;
            byte_en        <= 1'b0;
            byte_er        <= 1'b0;
            crc_en         <= 1'b0;
            crc_slot       <= 1'b0;
        end else begin
            byte_data <= data_d;
            byte_en   <= en_d;
            byte_er   <= er_d;
            crc_en    <= crc_en_d;
            crc_slot  <= slot_d;
            if (phase == eth_mac_pkg::PH_IDLE) begin
                if (pkt_valid) begin
                    len_q <= pkt_len;
                    cnt   <= '0;
                    phase <= eth_mac_pkg::PH_PREAMBLE;
                end
            end else if (last) begin
                cnt   <= '0;
                phase <= phase_nxt;
                if (phase == eth_mac_pkg::PH_CRC) begin
                    packet_counter <= packet_counter + 32'd1;
                end
            end else begin
                cnt <= cnt + `ETH_LEN_W'(1);
            end
        end
    end

    len_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pkt_valid && pkt_ready) |-> (pkt_len >= 1 && pkt_len <= `ETH_MAX_PAYLOAD)
    ) else $error("pkt_len %0d out of range", pkt_len);

    // Link idle for the full gap before the next frame starts
    gap_is_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(byte_en) |-> !$past(byte_en, `ETH_IFG_LEN)
    ) else $error("frame byte during inter-frame gap");

endmodule

// ==== crc32_appender.sv ====
// ==============================
// CRC-32 appender
// Accumulates the frame CRC, fills the CRC slot
// and registers the GMII outputs
// ==============================

`include "eth_mac_settings.svh"

module crc32_appender (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_en,
    input  logic       byte_er,
    input  logic       crc_en,
    input  logic       crc_slot,
    output logic [7:0] gmii_tx_d,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    logic [31:0] crc_q;  // Running CRC, then shift register for the slot

    // ==============================
    // CRC accumulation
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= `ETH_CRC_INIT;
        end else if (!byte_en) begin
            crc_q <= `ETH_CRC_INIT;  // Between frames
        end else if (crc_en) begin
            crc_q <= eth_mac_pkg::crc32_update(crc_q, byte_data);
        end else if (crc_slot) begin
            crc_q <= {8'h00, crc_q[31:8]};  // Next byte into position
        end
    end

    // ==============================
    // GMII output register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii_tx_d  <= 8'h00;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else begin
            gmii_tx_en <= byte_en;
            gmii_tx_er <= byte_er;
            if (crc_slot) begin
                gmii_tx_d <= ~crc_q[7:0];  // Inverted, LSB first
            end else begin
                gmii_tx_d <= byte_data;
            end
        end
    end

    // Slot only follows CRC-covered bytes within one frame
    slot_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(crc_slot) |-> $past(crc_en) && $past(byte_en)
    ) else $error("CRC slot without preceding payload");

endmodule

// ==== eth_mac_tx.sv ====
// ==============================
// Gigabit Ethernet MAC transmitter
// Host frames and words in, GMII out
// ==============================

`include "eth_mac_settings.svh"

module eth_mac_tx (
    input  logic                  clk,
    input  logic                  rst_n,

    // Frame handshake
    input  logic                  pkt_valid,
    input  logic [`ETH_LEN_W-1:0] pkt_len,
    output logic                  pkt_ready,

    // Payload words, first byte in 7:0
    input  logic                  word_valid,
    input  logic [31:0]           word_data,
    output logic                  word_ready,

    // GMII transmit
    output logic [7:0]            gmii_tx_d,
    output logic                  gmii_tx_en,
    output logic                  gmii_tx_er,

    output logic [31:0]           packet_counter
);

    payload_byte_if pb_if ();

    // Sequencer to CRC stage
    logic [7:0] byte_data;
    logic       byte_en;
    logic       byte_er;
    logic       crc_en;
    logic       crc_slot;

    payload_unpacker unpacker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_ready (word_ready),
        .pb         (pb_if.unpacker)
    );

    tx_frame_sequencer sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pkt_valid      (pkt_valid),
        .pkt_len        (pkt_len),
        .pkt_ready      (pkt_ready),
        .pb             (pb_if.sequencer),
        .byte_data      (byte_data),
        .byte_en        (byte_en),
        .byte_er        (byte_er),
        .crc_en         (crc_en),
        .crc_slot       (crc_slot),
        .packet_counter (packet_counter)
    );

    crc32_appender crc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_en    (byte_en),
        .byte_er    (byte_er),
        .crc_en     (crc_en),
        .crc_slot   (crc_slot),
        .gmii_tx_d  (gmii_tx_d),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

// ==== tb_eth_mac_tx.sv ====
// ==============================
// Testbench for the Ethernet MAC transmitter
// Table-driven frames checked against a reference frame and CRC model
// ==============================

`include "eth_mac_settings.svh"

module tb_eth_mac_tx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_FRAMES     = 10;
    localparam int HEAD_LEN     = `ETH_PREAMBLE_LEN + 1 + `ETH_HDR_LEN;  // Preamble to EtherType
    localparam int OVERHEAD     = HEAD_LEN + 4;                          // Plus CRC
    localparam int MAX_BYTES    = 1504;
    localparam int STALL_CYCLES = 8;

    localparam logic [47:0] SRC_MAC    = `ETH_LOCAL_MAC;
    localparam logic [15:0] ETHER_TYPE = `ETH_TYPE_IPV4;

    // Payload length and withheld word index per frame, -1 for no stall
    localparam int LENS   [N_FRAMES] = '{1, 3, 4, 5, 64, 17, 1500, 40, 2, 46};
    localparam int STALLS [N_FRAMES] = '{-1, -1, -1, -1, -1, 3, -1, 2, -1, -1};

    logic                  clk;
    logic                  rst_n;
    logic                  pkt_valid;
    logic [`ETH_LEN_W-1:0] pkt_len;
    logic                  pkt_ready;
    logic                  word_valid;
    logic [31:0]           word_data;
    logic                  word_ready;
    logic [7:0]            gmii_tx_d;
    logic                  gmii_tx_en;
    logic                  gmii_tx_er;
    logic [31:0]           packet_counter;

    int         seed;
    int         errors = 0;
    int         cyc = 0;        // Rising edges so far
    int         accept_cyc;
    int         busy_cycles;
    logic [7:0] pay [MAX_BYTES];
    logic [7:0] exp_q [$];

    // Capture state
    logic [7:0] cap_q [$];
    logic       en_prev = 1'b0;
    logic       er_seen = 1'b0;
    int         rise_cyc = 0;
    int         fall_cyc = 0;
    int         frames_seen = 0;

    eth_mac_tx dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pkt_valid      (pkt_valid),
        .pkt_len        (pkt_len),
        .pkt_ready      (pkt_ready),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_ready     (word_ready),
        .gmii_tx_d      (gmii_tx_d),
        .gmii_tx_en     (gmii_tx_en),
        .gmii_tx_er     (gmii_tx_er),
        .packet_counter (packet_counter)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ==============================
    // GMII monitor
    // ==============================
    always @(negedge clk) begin
        if (gmii_tx_en) begin
            if (!en_prev) begin
                if (frames_seen > 0 && cyc - fall_cyc < `ETH_IFG_LEN) begin
                    errors++;
                    $display("Idle gap of %0d cycles before a frame is shorter than %0d",
                             cyc - fall_cyc, `ETH_IFG_LEN);
                end
                cap_q.delete();
                er_seen  = 1'b0;
                rise_cyc = cyc;
            end
            cap_q.push_back(gmii_tx_d);
            if (gmii_tx_er) begin
                er_seen = 1'b1;
            end
        end else if (en_prev) begin
            fall_cyc = cyc;
            frames_seen++;
        end
        en_prev = gmii_tx_en;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    // Bit-serial CRC-32, reflected
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    // Expected wire bytes for the current payload
    task automatic build_frame(input int len);
        logic [31:0] crc;
        exp_q.delete();
        for (int k = 0; k < `ETH_PREAMBLE_LEN; k++) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(`ETH_SFD);
        for (int k = 0; k < 6; k++) begin
            exp_q.push_back(8'hFF);  // Broadcast
        end
        for (int k = 5; k >= 0; k--) begin
            exp_q.push_back(SRC_MAC[k*8 +: 8]);
        end
        exp_q.push_back(ETHER_TYPE[15:8]);
        exp_q.push_back(ETHER_TYPE[7:0]);
        for (int k = 0; k < len; k++) begin
            exp_q.push_back(pay[k]);
        end
        crc = `ETH_CRC_INIT;
        for (int k = `ETH_PREAMBLE_LEN + 1; k < exp_q.size(); k++) begin
            crc = crc_step(crc, exp_q[k]);  // Header and payload only
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(crc[k*8 +: 8]);
        end
    endtask

    // Host words, one of them held back on a stalled frame
    task automatic drive_words(input int len, input int stall);
        int n;
        int w;
        int hold;
        n    = (len + 3) / 4;
        w    = 0;
        hold = 0;
        for (int k = 0; k < len + OVERHEAD && w < n; k++) begin
            if (w == stall && hold < STALL_CYCLES) begin
                word_valid = 1'b0;
                hold++;
            end else begin
                word_valid = 1'b1;
                word_data  = {pay[4*w+3], pay[4*w+2], pay[4*w+1], pay[4*w]};
                if (word_ready) begin
                    w++;  // Taken at the next rising edge
                end
            end
            @(negedge clk);
        end
        word_valid = 1'b0;  // Leftover words of a stalled frame are dropped
    endtask

    // Starts at a falling edge, returns once pkt_ready is back
    task automatic send_frame(input int len, input int stall);
        while (!pkt_ready) begin
            @(negedge clk);
        end
        pkt_valid   = 1'b1;
        pkt_len     = `ETH_LEN_W'(len);
        accept_cyc  = cyc;
        busy_cycles = 0;
        fork
            drive_words(len, stall);
            begin
                @(negedge clk);
                pkt_valid = 1'b0;
                while (!pkt_ready) begin
                    busy_cycles++;
                    @(negedge clk);
                end
            end
        join
    endtask

    function automatic int run_budget();
        int total;
        total = 16 + 100;
        for (int i = 0; i < N_FRAMES; i++) begin
            total += LENS[i] + OVERHEAD + `ETH_IFG_LEN + 16;
        end
        return total;
    endfunction

    // Watchdog
    initial begin
        repeat (run_budget()) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles, errors: %0d",
                 run_budget(), errors);
        $display("Test failed");
        $finish;
    end

    // ==============================
    // Stimulus and checks
    // ==============================
    initial begin
        int          len;
        int          stall;
        logic [31:0] rnd;
        seed       = 32'h0c77a711;
        rst_n      = 1'b0;
        pkt_valid  = 1'b0;
        pkt_len    = '0;
        word_valid = 1'b0;
        word_data  = 32'h0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("gmii_tx_en", 32'h0, 32'(gmii_tx_en));
        check_value("gmii_tx_er", 32'h0, 32'(gmii_tx_er));
        check_value("word_ready", 32'h0, 32'(word_ready));
        check_value("pkt_ready", 32'h1, 32'(pkt_ready));
        check_value("packet_counter", 32'h0, packet_counter);

        for (int i = 0; i < N_FRAMES; i++) begin
            len   = LENS[i];
            stall = STALLS[i];
            for (int k = 0; k < 4 * ((len + 3) / 4); k++) begin
                rnd    = $random(seed);
                pay[k] = rnd[7:0];
            end
            build_frame(len);
            send_frame(len, stall);

            // Edge that ends A+2 shows at the falling edge of A+3
            check_value("gmii_tx_en rise delay", 32'd3, rise_cyc - accept_cyc);
            check_value("gmii_tx_en high cycles", len + OVERHEAD, fall_cyc - rise_cyc);
            check_value("pkt_ready low cycles", len + OVERHEAD + `ETH_IFG_LEN, busy_cycles);
            check_value("packet_counter", i + 1, packet_counter);
            check_value("frames on gmii_tx_en", i + 1, frames_seen);
            check_value("gmii_tx_er seen", 32'(stall >= 0), 32'(er_seen));
            for (int k = 0; k < cap_q.size() && k < exp_q.size(); k++) begin
                if (stall < 0 || k < HEAD_LEN) begin  // Stalled payload is shifted
                    check_value($sformatf("gmii_tx_d byte %0d", k), 32'(exp_q[k]),
                                32'(cap_q[k]));
                end
            end
        end

        $display("Frames sent: %0d, errors: %0d", N_FRAMES, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== eth_mac_tx.f ====
+incdir+.
eth_mac_pkg.sv
payload_byte_if.sv
payload_unpacker.sv
tx_frame_sequencer.sv
crc32_appender.sv
eth_mac_tx.sv
tb_eth_mac_tx.sv

// ==== Makefile ====
TOP := tb_eth_mac_tx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f eth_mac_tx.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
